//--- rtl/trap_pkg.sv
// trap unit shared definitions
package trap_pkg;

  // machine-mode CSR addresses
  localparam logic [11:0] CSR_MSTATUS = 12'h300;
  localparam logic [11:0] CSR_MIE     = 12'h304;
  localparam logic [11:0] CSR_MTVEC   = 12'h305;
  localparam logic [11:0] CSR_MEPC    = 12'h341;
  localparam logic [11:0] CSR_MCAUSE  = 12'h342;
  localparam logic [11:0] CSR_MTVAL   = 12'h343;
  localparam logic [11:0] CSR_MIP     = 12'h344;

  // mcause code field below the interrupt flag in bit 31
  typedef logic [3:0] cause_code_t;

  // synchronous exception causes
  localparam cause_code_t EXC_INST_MISAL  = 4'd0;
  localparam cause_code_t EXC_INST_ACC    = 4'd1;
  localparam cause_code_t EXC_ILLEGAL     = 4'd2;
  localparam cause_code_t EXC_BREAK       = 4'd3;
  localparam cause_code_t EXC_LOAD_MISAL  = 4'd4;
  localparam cause_code_t EXC_LOAD_ACC    = 4'd5;
  localparam cause_code_t EXC_STORE_MISAL = 4'd6;
  localparam cause_code_t EXC_STORE_ACC   = 4'd7;
  localparam cause_code_t EXC_ECALL_M     = 4'd11;
  localparam cause_code_t EXC_INST_PAGE   = 4'd12;
  localparam cause_code_t EXC_LOAD_PAGE   = 4'd13;
  localparam cause_code_t EXC_STORE_PAGE  = 4'd15;

  // interrupt causes double as mie and mip bit positions
  localparam cause_code_t IRQ_SOFT  = 4'd3;
  localparam cause_code_t IRQ_TIMER = 4'd7;
  localparam cause_code_t IRQ_EXT   = 4'd11;

  // mstatus bit positions
  localparam int MSTATUS_MIE  = 3;
  localparam int MSTATUS_MPIE = 7;

  // MPP field in bits 12:11 hardwired to machine mode
  localparam logic [31:0] MSTATUS_MPP = 32'h0000_1800;

  // writable mie bits and implemented mip bits
  localparam logic [31:0] MIE_MASK = 32'h0000_0888;

endpackage

//--- rtl/trap_if.sv
// decode to commit trap link
`timescale 1ns/1ps

interface trap_if;

  // one-cycle event from the decode stage
  logic                  valid;
  logic                  is_itrp;
  logic                  is_mret;
  trap_pkg::cause_code_t code;
  logic [31:0]           epc;
  logic [31:0]           tval;

  // status fed back from the commit stage
  logic                  glob_ie;
  // enables for soft, timer, ext in bits 0, 1, 2
  logic [2:0]            irq_en;

  modport decode (
    output valid, is_itrp, is_mret, code, epc, tval,
    input  glob_ie, irq_en
  );

  modport commit (
    input  valid, is_itrp, is_mret, code, epc, tval,
    output glob_ie, irq_en
  );

endinterface

//--- rtl/trap_decode.sv
// trap event decode stage
`timescale 1ns/1ps

module trap_decode (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        commit_valid,
  input  logic [31:0] commit_pc,
  input  logic [31:0] commit_inst,
  input  logic [31:0] mem_addr,
  input  logic [15:0] excp_flags,
  input  logic        mret,
  input  logic        irq_soft,
  input  logic        irq_timer,
  input  logic        irq_ext,
  trap_if.decode      ev
);

  // flag positions that carry a defined exception cause
  localparam logic [15:0] EXC_DEFINED =
      (16'd1 << trap_pkg::EXC_INST_MISAL)  | (16'd1 << trap_pkg::EXC_INST_ACC)
    | (16'd1 << trap_pkg::EXC_ILLEGAL)     | (16'd1 << trap_pkg::EXC_BREAK)
    | (16'd1 << trap_pkg::EXC_LOAD_MISAL)  | (16'd1 << trap_pkg::EXC_LOAD_ACC)
    | (16'd1 << trap_pkg::EXC_STORE_MISAL) | (16'd1 << trap_pkg::EXC_STORE_ACC)
    | (16'd1 << trap_pkg::EXC_ECALL_M)     | (16'd1 << trap_pkg::EXC_INST_PAGE)
    | (16'd1 << trap_pkg::EXC_LOAD_PAGE)   | (16'd1 << trap_pkg::EXC_STORE_PAGE);

  logic                  soft_ok;
  logic                  timer_ok;
  logic                  ext_ok;
  logic                  itrp_hit;
  logic [15:0]           excp_live;
  logic                  excp_hit;
  logic                  take;
  logic                  is_itrp_d;
  logic                  is_mret_d;
  trap_pkg::cause_code_t excp_code;
  trap_pkg::cause_code_t code_d;
  logic [31:0]           tval_d;

  // interrupt gating by global and per-source enables
  assign soft_ok  = ev.glob_ie & ev.irq_en[0] & irq_soft;
  assign timer_ok = ev.glob_ie & ev.irq_en[1] & irq_timer;
  assign ext_ok   = ev.glob_ie & ev.irq_en[2] & irq_ext;
  assign itrp_hit = soft_ok | timer_ok | ext_ok;

  assign excp_live = excp_flags & EXC_DEFINED;
  assign excp_hit  = |excp_live;

  // inputs ignored while an event waits in the stage register
  assign take = commit_valid & ~ev.valid & (itrp_hit | excp_hit | mret);

  // lowest set cause code wins
  always_comb begin
    excp_code = trap_pkg::EXC_INST_MISAL;
    for (int i = 15; i >= 0; i--) begin
      if (excp_live[i]) begin
        excp_code = 4'(i);
      end
    end
  end

  // interrupt over exception over mret
  always_comb begin
    is_itrp_d = 1'b0;
    is_mret_d = 1'b0;
    code_d    = excp_code;
    if (ext_ok) begin
      is_itrp_d = 1'b1;
      code_d    = trap_pkg::IRQ_EXT;
    end else if (soft_ok) begin
      is_itrp_d = 1'b1;
      code_d    = trap_pkg::IRQ_SOFT;
    end else if (timer_ok) begin
      is_itrp_d = 1'b1;
      code_d    = trap_pkg::IRQ_TIMER;
    end else if (!excp_hit) begin
      is_mret_d = 1'b1;
      code_d    = '0;
    end
  end

  // trap value by cause
  always_comb begin
    tval_d = '0;
    if (!is_itrp_d && !is_mret_d) begin
      case (code_d)
        trap_pkg::EXC_INST_MISAL, trap_pkg::EXC_INST_ACC, trap_pkg::EXC_INST_PAGE:
          tval_d = commit_pc;
        trap_pkg::EXC_ILLEGAL:
          tval_d = commit_inst;
        trap_pkg::EXC_LOAD_MISAL, trap_pkg::EXC_LOAD_ACC, trap_pkg::EXC_STORE_MISAL,
        trap_pkg::EXC_STORE_ACC, trap_pkg::EXC_LOAD_PAGE, trap_pkg::EXC_STORE_PAGE:
          tval_d = mem_addr;
        default:
          tval_d = '0;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ev.valid <= 1'b0;
    end else begin
      ev.valid <= take;
    end
  end

  // event payload
  always_ff @(posedge clk) begin
    if (take) begin
      ev.is_itrp <= is_itrp_d;
      ev.is_mret <= is_mret_d;
      ev.code    <= code_d;
      ev.epc     <= commit_pc;
      ev.tval    <= tval_d;
    end
  end

endmodule

//--- rtl/trap_commit.sv
// trap CSR commit stage
`timescale 1ns/1ps

module trap_commit #(
  parameter logic [31:0] MTVEC_RESET = 32'h0000_1000
) (
  input  logic        clk,
  input  logic        rst_n,
  trap_if.commit      ev,
  input  logic        irq_soft,
  input  logic        irq_timer,
  input  logic        irq_ext,
  input  logic        csr_we,
  input  logic [11:0] csr_addr,
  input  logic [31:0] csr_wdata,
  output logic [31:0] csr_rdata,
  output logic        redirect_valid,
  output logic [31:0] redirect_pc,
  output logic        trap_taken
);

  logic        mstatus_mie;
  logic        mstatus_mpie;
  logic [31:0] mie_q;
  logic [31:0] mtvec_q;
  logic [31:0] mepc_q;
  logic [31:0] mcause_q;
  logic [31:0] mtval_q;

  logic [31:0] mstatus_rd;
  logic [31:0] mip_rd;
  logic        trap_enter;
  logic        trap_exit;
  logic [31:0] vec_base;
  logic [31:0] trap_target;

  logic        sw_mstatus;
  logic        sw_mie;
  logic        sw_mtvec;
  logic        sw_mepc;
  logic        sw_mcause;
  logic        sw_mtval;

  assign trap_enter = ev.valid & ~ev.is_mret;
  assign trap_exit  = ev.valid & ev.is_mret;

  // status back to decode
  assign ev.glob_ie = mstatus_mie;
  assign ev.irq_en  = {mie_q[trap_pkg::IRQ_EXT], mie_q[trap_pkg::IRQ_TIMER],
                       mie_q[trap_pkg::IRQ_SOFT]};

  assign sw_mstatus = csr_we & (csr_addr == trap_pkg::CSR_MSTATUS);
  assign sw_mie     = csr_we & (csr_addr == trap_pkg::CSR_MIE);
  assign sw_mtvec   = csr_we & (csr_addr == trap_pkg::CSR_MTVEC);
  assign sw_mepc    = csr_we & (csr_addr == trap_pkg::CSR_MEPC);
  assign sw_mcause  = csr_we & (csr_addr == trap_pkg::CSR_MCAUSE);
  assign sw_mtval   = csr_we & (csr_addr == trap_pkg::CSR_MTVAL);

  // trap or mret update beats a software write
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mstatus_mie  <= 1'b0;
      mstatus_mpie <= 1'b0;
    end else if (trap_enter) begin
      mstatus_mpie <= mstatus_mie;
      mstatus_mie  <= 1'b0;
    end else if (trap_exit) begin
      mstatus_mie  <= mstatus_mpie;
      mstatus_mpie <= 1'b1;
    end else if (sw_mstatus) begin
      mstatus_mie  <= csr_wdata[trap_pkg::MSTATUS_MIE];
      mstatus_mpie <= csr_wdata[trap_pkg::MSTATUS_MPIE];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mie_q   <= '0;
      mtvec_q <= MTVEC_RESET & ~32'h2;
    end else begin
      if (sw_mie) begin
        mie_q <= csr_wdata & trap_pkg::MIE_MASK;
      end
      // bit 1 reserved so only modes 0 and 1 exist
      if (sw_mtvec) begin
        mtvec_q <= csr_wdata & ~32'h2;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mepc_q   <= '0;
      mcause_q <= '0;
      mtval_q  <= '0;
    end else if (trap_enter) begin
      mepc_q   <= {ev.epc[31:2], 2'b00};
      mcause_q <= {ev.is_itrp, 27'b0, ev.code};
      mtval_q  <= ev.tval;
    end else begin
      if (sw_mepc) begin
        mepc_q <= {csr_wdata[31:2], 2'b00};
      end
      if (sw_mcause) begin
        mcause_q <= csr_wdata;
      end
      if (sw_mtval) begin
        mtval_q <= csr_wdata;
      end
    end
  end

  // vectored mode offsets interrupts only
  assign vec_base    = {mtvec_q[31:2], 2'b00};
  assign trap_target = (mtvec_q[0] && ev.is_itrp) ?
                       vec_base + {26'b0, ev.code, 2'b00} : vec_base;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      redirect_valid <= 1'b0;
      trap_taken     <= 1'b0;
      redirect_pc    <= '0;
    end else begin
      redirect_valid <= ev.valid;
      trap_taken     <= trap_enter;
      if (ev.valid) begin
        redirect_pc <= trap_exit ? mepc_q : trap_target;
      end
    end
  end

  always_comb begin
    mstatus_rd = trap_pkg::MSTATUS_MPP;
    mstatus_rd[trap_pkg::MSTATUS_MIE]  = mstatus_mie;
    mstatus_rd[trap_pkg::MSTATUS_MPIE] = mstatus_mpie;
  end

  // mip mirrors the request levels
  always_comb begin
    mip_rd = '0;
    mip_rd[trap_pkg::IRQ_SOFT]  = irq_soft;
    mip_rd[trap_pkg::IRQ_TIMER] = irq_timer;
    mip_rd[trap_pkg::IRQ_EXT]   = irq_ext;
  end

  always_comb begin
    case (csr_addr)
      trap_pkg::CSR_MSTATUS: csr_rdata = mstatus_rd;
      trap_pkg::CSR_MIE:     csr_rdata = mie_q;
      trap_pkg::CSR_MTVEC:   csr_rdata = mtvec_q;
      trap_pkg::CSR_MEPC:    csr_rdata = mepc_q;
      trap_pkg::CSR_MCAUSE:  csr_rdata = mcause_q;
      trap_pkg::CSR_MTVAL:   csr_rdata = mtval_q;
      trap_pkg::CSR_MIP:     csr_rdata = mip_rd;
      default:               csr_rdata = '0;
    endcase
  end

endmodule

//--- rtl/trap_unit.sv
// machine-mode trap unit
`timescale 1ns/1ps

module trap_unit #(
  parameter logic [31:0] MTVEC_RESET = 32'h0000_1000
) (
  input  logic        clk,
  input  logic        rst_n,
  // committing instruction
  input  logic        commit_valid,
  input  logic [31:0] commit_pc,
  input  logic [31:0] commit_inst,
  input  logic [31:0] mem_addr,
  input  logic [15:0] excp_flags,
  input  logic        mret,
  // interrupt request levels
  input  logic        irq_soft,
  input  logic        irq_timer,
  input  logic        irq_ext,
  // CSR access from the core
  input  logic        csr_we,
  input  logic [11:0] csr_addr,
  input  logic [31:0] csr_wdata,
  output logic [31:0] csr_rdata,
  // fetch redirect
  output logic        redirect_valid,
  output logic [31:0] redirect_pc,
  output logic        trap_taken
);

  trap_if ev ();

  trap_decode u_decode (
    .clk          (clk),
    .rst_n        (rst_n),
    .commit_valid (commit_valid),
    .commit_pc    (commit_pc),
    .commit_inst  (commit_inst),
    .mem_addr     (mem_addr),
    .excp_flags   (excp_flags),
    .mret         (mret),
    .irq_soft     (irq_soft),
    .irq_timer    (irq_timer),
    .irq_ext      (irq_ext),
    .ev           (ev.decode)
  );

  trap_commit #(
    .MTVEC_RESET (MTVEC_RESET)
  ) u_commit (
    .clk            (clk),
    .rst_n          (rst_n),
    .ev             (ev.commit),
    .irq_soft       (irq_soft),
    .irq_timer      (irq_timer),
    .irq_ext        (irq_ext),
    .csr_we         (csr_we),
    .csr_addr       (csr_addr),
    .csr_wdata      (csr_wdata),
    .csr_rdata      (csr_rdata),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .trap_taken     (trap_taken)
  );

endmodule

//--- bench/trap_unit_assertions.sv
// trap commit assertions
`timescale 1ns/1ps

module trap_unit_assertions (
  input logic        clk,
  input logic        rst_n,
  input logic        trap_enter,
  input logic        mstatus_mie,
  input logic        redirect_valid,
  input logic [31:0] redirect_pc,
  input logic        trap_taken
);

  // redirects are single-cycle pulses
  redirect_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    redirect_valid |=> !redirect_valid)
    else $error("redirect_valid held high for two cycles");

  redirect_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    redirect_valid |-> (redirect_pc[1:0] == 2'b00))
    else $error("redirect_pc is not word aligned");

  // entry always masks interrupts
  mie_cleared: assert property (@(posedge clk) disable iff (!rst_n)
    trap_enter |=> !mstatus_mie)
    else $error("mstatus MIE still set after trap entry");

  taken_with_redirect: assert property (@(posedge clk) disable iff (!rst_n)
    trap_taken |-> redirect_valid)
    else $error("trap_taken without redirect_valid");

endmodule

bind trap_commit trap_unit_assertions u_assertions (
  .clk            (clk),
  .rst_n          (rst_n),
  .trap_enter     (trap_enter),
  .mstatus_mie    (mstatus_mie),
  .redirect_valid (redirect_valid),
  .redirect_pc    (redirect_pc),
  .trap_taken     (trap_taken)
);

//--- bench/trap_unit_tb.sv
// trap unit testbench
`timescale 1ns/1ps

module trap_unit_tb;

  localparam logic [31:0] MTVEC_INIT  = 32'h0000_1000;
  // flag positions with a defined exception cause
  localparam logic [15:0] EXC_DEFINED = 16'hB8FF;
  localparam int          WAIT_LIMIT  = 8;

  logic        clk;
  logic        rst_n;
  logic        commit_valid;
  logic [31:0] commit_pc;
  logic [31:0] commit_inst;
  logic [31:0] mem_addr;
  logic [15:0] excp_flags;
  logic        mret;
  logic        irq_soft;
  logic        irq_timer;
  logic        irq_ext;
  logic        csr_we;
  logic [11:0] csr_addr;
  logic [31:0] csr_wdata;
  logic [31:0] csr_rdata;
  logic        redirect_valid;
  logic [31:0] redirect_pc;
  logic        trap_taken;

  // reference CSR state
  logic        ref_gie;
  logic        ref_pie;
  logic [31:0] ref_mie;
  logic [31:0] ref_mtvec;
  logic [31:0] ref_mepc;
  logic [31:0] ref_mcause;
  logic [31:0] ref_mtval;

  // predicted event
  logic                  exp_hit;
  logic                  exp_itrp;
  logic                  exp_mret;
  trap_pkg::cause_code_t exp_code;
  logic [31:0]           exp_tval;
  logic [31:0]           exp_target;
  logic [31:0]           lcg_state;

  trap_unit #(.MTVEC_RESET(MTVEC_INIT)) UUT (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("error at %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("error at %0t: %s is %b, expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_code(input string name, input trap_pkg::cause_code_t got,
                            input trap_pkg::cause_code_t exp);
    if (got !== exp) begin
      fail_run($sformatf("error at %0t: %s is %0d, expected %0d", $time, name, got, exp));
    end
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // gating, priority and trap value rules
  task automatic predict_event();
    logic [15:0] live;
    logic        s_ok;
    logic        t_ok;
    logic        e_ok;
    live     = excp_flags & EXC_DEFINED;
    s_ok     = ref_gie & ref_mie[3] & irq_soft;
    t_ok     = ref_gie & ref_mie[7] & irq_timer;
    e_ok     = ref_gie & ref_mie[11] & irq_ext;
    exp_itrp = e_ok | s_ok | t_ok;
    exp_hit  = commit_valid & (exp_itrp | (|live) | mret);
    exp_mret = !exp_itrp && (~|live) && mret;
    exp_tval = '0;
    exp_code = 4'd0;
    if (e_ok) exp_code = 4'd11;
    else if (s_ok) exp_code = 4'd3;
    else if (t_ok) exp_code = 4'd7;
    else begin
      for (int i = 15; i >= 0; i--) begin
        if (live[i]) exp_code = 4'(i);
      end
      if (!exp_mret) begin
        case (exp_code)
          4'd0, 4'd1, 4'd12: exp_tval = commit_pc;
          4'd2: exp_tval = commit_inst;
          4'd4, 4'd5, 4'd6, 4'd7, 4'd13, 4'd15: exp_tval = mem_addr;
          default: exp_tval = '0;
        endcase
      end
    end
  endtask

  task automatic apply_event();
    logic [31:0] base;
    base = {ref_mtvec[31:2], 2'b00};
    if (exp_mret) begin
      exp_target = ref_mepc;
      ref_gie    = ref_pie;
      ref_pie    = 1'b1;
    end else begin
      exp_target = (ref_mtvec[0] && exp_itrp) ? base + {26'b0, exp_code, 2'b00} : base;
      ref_mepc   = {commit_pc[31:2], 2'b00};
      ref_mcause = {exp_itrp, 27'b0, exp_code};
      ref_mtval  = exp_tval;
      ref_pie    = ref_gie;
      ref_gie    = 1'b0;
    end
  endtask

  task automatic check_csr(input string name, input logic [11:0] addr, input logic [31:0] exp);
    csr_addr = addr;
    #1;
    check_word(name, csr_rdata, exp);
  endtask

  task automatic check_csrs();
    check_csr("mstatus", trap_pkg::CSR_MSTATUS,
              32'h1800 | {24'b0, ref_pie, 3'b0, ref_gie, 3'b0});
    check_csr("mie", trap_pkg::CSR_MIE, ref_mie);
    check_csr("mtvec", trap_pkg::CSR_MTVEC, ref_mtvec);
    check_csr("mepc", trap_pkg::CSR_MEPC, ref_mepc);
    check_csr("mcause", trap_pkg::CSR_MCAUSE, ref_mcause);
    check_csr("mtval", trap_pkg::CSR_MTVAL, ref_mtval);
    check_csr("mip", trap_pkg::CSR_MIP,
              {20'b0, irq_ext, 3'b0, irq_timer, 3'b0, irq_soft, 3'b0});
  endtask

  task automatic csr_write(input logic [11:0] addr, input logic [31:0] data);
    csr_we    = 1'b1;
    csr_addr  = addr;
    csr_wdata = data;
    @(negedge clk);
    csr_we = 1'b0;
    case (addr)
      trap_pkg::CSR_MSTATUS: begin
        ref_gie = data[3];
        ref_pie = data[7];
      end
      trap_pkg::CSR_MIE:    ref_mie = data & 32'h0000_0888;
      trap_pkg::CSR_MTVEC:  ref_mtvec = data & ~32'h2;
      trap_pkg::CSR_MEPC:   ref_mepc = {data[31:2], 2'b00};
      trap_pkg::CSR_MCAUSE: ref_mcause = data;
      trap_pkg::CSR_MTVAL:  ref_mtval = data;
      default: ;
    endcase
  endtask

  // one commit followed by the redirect and CSR compare
  task automatic run_commit(input logic valid_in, input logic [31:0] pc,
                            input logic [15:0] flags, input logic mret_in);
    int n;
    commit_valid = valid_in;
    commit_pc    = pc;
    commit_inst  = ~pc;
    mem_addr     = pc ^ 32'h5a5a_0f0f;
    excp_flags   = flags;
    mret         = mret_in;
    predict_event();
    if (exp_hit) apply_event();
    @(negedge clk);
    commit_valid = 1'b0;
    excp_flags   = '0;
    mret         = 1'b0;
    n = 0;
    while (!redirect_valid && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (exp_hit) begin
      if (!redirect_valid) fail_run("timeout waiting for redirect_valid after a trap event");
      check_word("redirect_pc", redirect_pc, exp_target);
      check_flag("trap_taken", trap_taken, !exp_mret);
      csr_addr = trap_pkg::CSR_MCAUSE;
      #1;
      if (!exp_mret) check_code("mcause code", csr_rdata[3:0], exp_code);
    end else if (redirect_valid) begin
      fail_run("redirect_valid rose although no trap event was committed");
    end
    check_csrs();
    repeat (2) @(negedge clk);
  endtask

  task automatic test_reset();
    check_flag("redirect_valid", redirect_valid, 1'b0);
    check_flag("trap_taken", trap_taken, 1'b0);
    check_csrs();
    @(negedge clk);
  endtask

  task automatic test_exceptions();
    for (int i = 0; i < 16; i++) begin
      if (EXC_DEFINED[i]) run_commit(1'b1, 32'h4003 + 32'(i << 4), 16'd1 << i, 1'b0);
    end
    run_commit(1'b1, 32'h5000, 16'hB8F0, 1'b1);
    run_commit(1'b1, 32'h5100, 16'hA804, 1'b0);
    run_commit(1'b1, 32'h5200, 16'h0700, 1'b0);
    run_commit(1'b0, 32'h5300, 16'h0001, 1'b0);
  endtask

  task automatic test_interrupts();
    irq_soft  = 1'b1;
    irq_timer = 1'b1;
    irq_ext   = 1'b1;
    csr_write(trap_pkg::CSR_MSTATUS, 32'h8);
    run_commit(1'b1, 32'h6000, 16'h0, 1'b0);
    csr_write(trap_pkg::CSR_MSTATUS, 32'h0);
    csr_write(trap_pkg::CSR_MIE, 32'hFFFF_FFFF);
    run_commit(1'b1, 32'h6010, 16'h0, 1'b0);
    // vectored mode with ext then soft then timer
    csr_write(trap_pkg::CSR_MTVEC, 32'h2001);
    for (int k = 0; k < 3; k++) begin
      csr_write(trap_pkg::CSR_MSTATUS, 32'h8);
      run_commit(1'b1, 32'h6100 + 32'(k << 4), 16'h0, 1'b0);
      if (k == 0) irq_ext = 1'b0;
      if (k == 1) irq_soft = 1'b0;
    end
    csr_write(trap_pkg::CSR_MTVEC, 32'h3000);
    csr_write(trap_pkg::CSR_MSTATUS, 32'h8);
    run_commit(1'b1, 32'h6200, 16'h0, 1'b0);
    irq_ext = 1'b1;
    csr_write(trap_pkg::CSR_MSTATUS, 32'h8);
    run_commit(1'b1, 32'h6300, 16'h0004, 1'b1);
    irq_soft  = 1'b0;
    irq_timer = 1'b0;
    irq_ext   = 1'b0;
  endtask

  task automatic test_mret();
    csr_write(trap_pkg::CSR_MSTATUS, 32'h8);
    run_commit(1'b1, 32'h7004, 16'h0008, 1'b0);
    run_commit(1'b1, 32'h7100, 16'h0, 1'b1);
    csr_write(trap_pkg::CSR_MSTATUS, 32'h0);
    run_commit(1'b1, 32'h7200, 16'h0800, 1'b0);
    run_commit(1'b1, 32'h7300, 16'h0, 1'b1);
  endtask

  task automatic test_csr_port();
    csr_write(trap_pkg::CSR_MSTATUS, 32'hFFFF_FFFF);
    csr_write(trap_pkg::CSR_MIE, 32'hFFFF_FFFF);
    csr_write(trap_pkg::CSR_MTVEC, 32'hFFFF_FFFF);
    csr_write(trap_pkg::CSR_MEPC, 32'hFFFF_FFFF);
    csr_write(trap_pkg::CSR_MCAUSE, 32'h8000_0007);
    csr_write(trap_pkg::CSR_MTVAL, 32'h1234_5678);
    csr_write(trap_pkg::CSR_MIP, 32'hFFFF_FFFF);
    check_csrs();
    @(negedge clk);
    irq_timer = 1'b1;
    #1;
    check_csrs();
    @(negedge clk);
    irq_timer = 1'b0;
    csr_write(trap_pkg::CSR_MTVEC, MTVEC_INIT);
    csr_write(trap_pkg::CSR_MSTATUS, 32'h0);
  endtask

  task automatic test_random();
    logic [31:0] r;
    logic [31:0] v;
    for (int k = 0; k < 40; k++) begin
      r = lcg_next();
      if (r[0]) csr_write(trap_pkg::CSR_MSTATUS, {24'b0, r[1], 3'b0, r[2], 3'b0});
      if (r[3]) csr_write(trap_pkg::CSR_MIE, lcg_next());
      if (r[4]) begin
        v = lcg_next();
        csr_write(trap_pkg::CSR_MTVEC, {v[31:8], 7'b0, r[5]});
      end
      irq_soft  = r[8];
      irq_timer = r[9];
      irq_ext   = r[10];
      v = lcg_next();
      run_commit(r[13] | r[14], lcg_next(), r[11] ? v[15:0] & EXC_DEFINED : 16'h0, r[12]);
    end
  endtask

  initial begin
    $timeformat(-9, 0, " ns", 0);
    lcg_state    = 32'h3370;
    rst_n        = 1'b0;
    commit_valid = 1'b0;
    commit_pc    = '0;
    commit_inst  = '0;
    mem_addr     = '0;
    excp_flags   = '0;
    mret         = 1'b0;
    irq_soft     = 1'b0;
    irq_timer    = 1'b0;
    irq_ext      = 1'b0;
    csr_we       = 1'b0;
    csr_addr     = '0;
    csr_wdata    = '0;
    ref_gie      = 1'b0;
    ref_pie      = 1'b0;
    ref_mie      = '0;
    ref_mtvec    = MTVEC_INIT;
    ref_mepc     = '0;
    ref_mcause   = '0;
    ref_mtval    = '0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    test_reset();
    test_exceptions();
    test_interrupts();
    test_mret();
    test_csr_port();
    test_random();
    $display("Test passed");
    $finish;
  end

endmodule

//--- all.f
rtl/trap_pkg.sv
rtl/trap_if.sv
rtl/trap_decode.sv
rtl/trap_commit.sv
rtl/trap_unit.sv
bench/trap_unit_assertions.sv
bench/trap_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the trap unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module trap_unit_tb \
  -f all.f \
  -o trap_unit_sim

./obj_dir/trap_unit_sim
